//--- src/invaders_pkg.sv
package invaders_pkg;

	//////////////////////////////
	// scan coordinates and visible area
	localparam int COORD_W = 11;
	localparam logic [COORD_W-1:0] SCREEN_W = 11'd640;
	localparam logic [COORD_W-1:0] SCREEN_H = 11'd480;

	//////////////////////////////
	// pixel colors, blue in the top bits, red at the bottom
	localparam int COLOR_W = 8;
	localparam logic [COLOR_W-1:0] COLOR_SPACE = 8'h00;
	localparam logic [COLOR_W-1:0] COLOR_WHITE = 8'hff;
	localparam logic [COLOR_W-1:0] COLOR_RED = 8'h07;
	localparam logic [COLOR_W-1:0] COLOR_GREEN = 8'h38;
	localparam logic [COLOR_W-1:0] COLOR_BLUE = 8'hc0;
	localparam logic [COLOR_W-1:0] COLOR_SHIP = 8'h78;
	localparam logic [COLOR_W-1:0] COLOR_ALIEN = 8'haa;
	localparam logic [COLOR_W-1:0] COLOR_LASER = 8'h3f;

	// divider rows of the game screen, row 0 is also a scoreboard line
	localparam logic [COORD_W-1:0] SCOREBOARD_BOTTOM = 11'd40;
	localparam logic [COORD_W-1:0] BARRIER_TOP = 11'd340;
	localparam logic [COORD_W-1:0] BARRIER_BOTTOM = 11'd400;
	localparam logic [COORD_W-1:0] EXTRA_LIVES_TOP = 11'd460;

	//////////////////////////////
	// formation layout, home corner is the restart position too
	localparam int ALIEN_COLS = 11;
	localparam int ALIEN_ROWS = 2;
	localparam logic [COORD_W-1:0] ALIEN_X0 = 11'd70;
	localparam logic [COORD_W-1:0] ALIEN_Y0 = 11'd90;
	localparam logic [COORD_W-1:0] ALIEN_PITCH_X = 11'd50;
	localparam logic [COORD_W-1:0] ALIEN_PITCH_Y = 11'd30;
	localparam logic [COORD_W-1:0] ALIEN_W = 11'd24;
	localparam logic [COORD_W-1:0] ALIEN_H = 11'd16;

	// formation motion, range is the largest horizontal offset
	localparam logic [COORD_W-1:0] MARCH_STEP = 11'd10;
	localparam logic [COORD_W-1:0] MARCH_RANGE = 11'd40;
	localparam logic [COORD_W-1:0] DROP_STEP = 11'd10;

	// ship
	localparam logic [COORD_W-1:0] SHIP_Y = 11'd420;
	localparam logic [COORD_W-1:0] SHIP_W = 11'd30;
	localparam logic [COORD_W-1:0] SHIP_H = 11'd12;
	localparam logic [COORD_W-1:0] SHIP_X0 = 11'd305;
	localparam logic [COORD_W-1:0] SHIP_STEP = 11'd5;

	// laser
	localparam logic [COORD_W-1:0] LASER_W = 11'd2;
	localparam logic [COORD_W-1:0] LASER_H = 11'd8;
	localparam logic [COORD_W-1:0] LASER_STEP = 11'd8;

	// screen modes, cycled by the display button
	localparam logic [1:0] MODE_BLANK = 2'd0;
	localparam logic [1:0] MODE_START = 2'd1;
	localparam logic [1:0] MODE_GAME = 2'd2;

endpackage

//--- src/shot_if.sv
`timescale 1ns/1ns

interface shot_if;

	// laser top-left corner and flight flag
	logic [invaders_pkg::COORD_W-1:0] laser_x;
	logic [invaders_pkg::COORD_W-1:0] laser_y;
	logic laser_active;
	// laser overlaps a living alien, combinational
	logic alien_hit;

	// ship side owns the laser
	modport shooter (
		output laser_x,
		output laser_y,
		output laser_active,
		input  alien_hit
	);

	// formation side reports the collision
	modport target (
		input  laser_x,
		input  laser_y,
		input  laser_active,
		output alien_hit
	);

endinterface

//--- src/player_ship.sv
`timescale 1ns/1ns

module player_ship (
	input  logic clk,
	input  logic rst,
	input  logic frame_tick,
	input  logic game_run,
	input  logic restart,
	input  logic button_left,
	input  logic button_right,
	input  logic button_shoot,
	input  logic [invaders_pkg::COORD_W-1:0] x_coord,
	input  logic [invaders_pkg::COORD_W-1:0] y_coord,
	shot_if.shooter shot,
	output logic ship_px,
	output logic laser_px
);

	logic [invaders_pkg::COORD_W-1:0] ship_x;
	logic [invaders_pkg::COORD_W-1:0] laser_x;
	logic [invaders_pkg::COORD_W-1:0] laser_y;
	logic laser_active;
	logic step;
	logic launch;
	logic laser_top_out;

	// motion only on frame ticks of a running game
	assign step = frame_tick & game_run;
	assign launch = step & ~laser_active & button_shoot;
	// next climb would put the top above the scoreboard line
	assign laser_top_out =
		laser_y < invaders_pkg::SCOREBOARD_BOTTOM + invaders_pkg::LASER_STEP;

	//////////////////////////////
	// ship position and laser flight flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ship_x <= invaders_pkg::SHIP_X0;
			laser_active <= 1'b0;
		end else if (restart) begin
			ship_x <= invaders_pkg::SHIP_X0;
			laser_active <= 1'b0;
		end else if (step) begin
			// left wins over right, clamp at both edges
			if (button_left) begin
				if (ship_x >= invaders_pkg::SHIP_STEP)
					ship_x <= ship_x - invaders_pkg::SHIP_STEP;
				else
					ship_x <= '0;
			end else if (button_right) begin
				if (ship_x + invaders_pkg::SHIP_STEP <=
						invaders_pkg::SCREEN_W - invaders_pkg::SHIP_W)
					ship_x <= ship_x + invaders_pkg::SHIP_STEP;
				else
					ship_x <= invaders_pkg::SCREEN_W - invaders_pkg::SHIP_W;
			end
			// hit and scoreboard both retire the shot
			if (laser_active) begin
				if (shot.alien_hit || laser_top_out)
					laser_active <= 1'b0;
			end else if (button_shoot) begin
				laser_active <= 1'b1;
			end
		end
	end

	// laser position, meaningless while idle
	always_ff @(posedge clk) begin
		if (launch) begin
			// centered on the ship, bottom touching its top
			laser_x <= ship_x + ((invaders_pkg::SHIP_W - invaders_pkg::LASER_W) >> 1);
			laser_y <= invaders_pkg::SHIP_Y - invaders_pkg::LASER_H;
		end else if (step && laser_active) begin
			laser_y <= laser_y - invaders_pkg::LASER_STEP;
		end
	end

	assign shot.laser_x = laser_x;
	assign shot.laser_y = laser_y;
	assign shot.laser_active = laser_active;

	//////////////////////////////
	// pixel flags for the current scan position
	assign ship_px = (x_coord >= ship_x) && (x_coord < ship_x + invaders_pkg::SHIP_W) &&
		(y_coord >= invaders_pkg::SHIP_Y) &&
		(y_coord < invaders_pkg::SHIP_Y + invaders_pkg::SHIP_H);
	assign laser_px = laser_active &&
		(x_coord >= laser_x) && (x_coord < laser_x + invaders_pkg::LASER_W) &&
		(y_coord >= laser_y) && (y_coord < laser_y + invaders_pkg::LASER_H);

endmodule

//--- src/alien_formation.sv
`timescale 1ns/1ns

module alien_formation (
	input  logic clk,
	input  logic rst,
	input  logic frame_tick,
	input  logic game_run,
	input  logic restart,
	input  logic [invaders_pkg::COORD_W-1:0] x_coord,
	input  logic [invaders_pkg::COORD_W-1:0] y_coord,
	shot_if.target shot,
	output logic alien_px
);

	// offsets from the home corner
	logic [invaders_pkg::COORD_W-1:0] march_x;
	logic [invaders_pkg::COORD_W-1:0] drop_y;
	logic dir_right;
	// bit index is row * cols + col, row 0 on top
	logic [invaders_pkg::ALIEN_ROWS*invaders_pkg::ALIEN_COLS-1:0] alive;
	logic [invaders_pkg::ALIEN_ROWS*invaders_pkg::ALIEN_COLS-1:0] overlap;
	logic [invaders_pkg::ALIEN_ROWS*invaders_pkg::ALIEN_COLS-1:0] hit_lowest;
	logic [invaders_pkg::ALIEN_ROWS*invaders_pkg::ALIEN_COLS-1:0] px;
	logic step;
	logic at_limit;

	assign step = frame_tick & game_run;
	// limit in the current direction of travel
	assign at_limit = dir_right ? (march_x == invaders_pkg::MARCH_RANGE) : (march_x == '0);

	//////////////////////////////
	// per alien rectangle, laser overlap and pixel
	always_comb begin
		logic [invaders_pkg::COORD_W-1:0] col_x;
		logic [invaders_pkg::COORD_W-1:0] row_y;
		row_y = invaders_pkg::ALIEN_Y0 + drop_y;
		col_x = '0;
		for (int r = 0; r < invaders_pkg::ALIEN_ROWS; r++) begin
			col_x = invaders_pkg::ALIEN_X0 + march_x;
			for (int c = 0; c < invaders_pkg::ALIEN_COLS; c++) begin
				// open-ended rectangle test against the laser
				overlap[r*invaders_pkg::ALIEN_COLS+c] =
					alive[r*invaders_pkg::ALIEN_COLS+c] && shot.laser_active &&
					(shot.laser_x < col_x + invaders_pkg::ALIEN_W) &&
					(shot.laser_x + invaders_pkg::LASER_W > col_x) &&
					(shot.laser_y < row_y + invaders_pkg::ALIEN_H) &&
					(shot.laser_y + invaders_pkg::LASER_H > row_y);
				px[r*invaders_pkg::ALIEN_COLS+c] =
					alive[r*invaders_pkg::ALIEN_COLS+c] &&
					(x_coord >= col_x) && (x_coord < col_x + invaders_pkg::ALIEN_W) &&
					(y_coord >= row_y) && (y_coord < row_y + invaders_pkg::ALIEN_H);
				col_x = col_x + invaders_pkg::ALIEN_PITCH_X;
			end
			row_y = row_y + invaders_pkg::ALIEN_PITCH_Y;
		end
	end

	// keep only the lowest set bit
	assign hit_lowest = overlap & (~overlap + 1'b1);

	assign shot.alien_hit = |overlap;
	assign alien_px = |px;

	//////////////////////////////
	// march, drop and kill
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			march_x <= '0;
			drop_y <= '0;
			dir_right <= 1'b1;
			alive <= '1;
		end else if (restart) begin
			march_x <= '0;
			drop_y <= '0;
			dir_right <= 1'b1;
			alive <= '1;
		end else if (step) begin
			if (at_limit) begin
				// step down instead of sideways, then turn
				drop_y <= drop_y + invaders_pkg::DROP_STEP;
				dir_right <= ~dir_right;
			end else if (dir_right) begin
				march_x <= march_x + invaders_pkg::MARCH_STEP;
			end else begin
				march_x <= march_x - invaders_pkg::MARCH_STEP;
			end
			// same level the ship uses to retire the laser
			alive <= alive & ~hit_lowest;
		end
	end

endmodule

//--- src/screen_compositor.sv
`timescale 1ns/1ns

module screen_compositor (
	input  logic clk,
	input  logic rst,
	input  logic button_display,
	input  logic [invaders_pkg::COORD_W-1:0] x_coord,
	input  logic [invaders_pkg::COORD_W-1:0] y_coord,
	input  logic ship_px,
	input  logic laser_px,
	input  logic alien_px,
	output logic game_run,
	output logic restart,
	output logic [invaders_pkg::COLOR_W-1:0] rgb
);

	logic [1:0] mode;
	logic visible;
	logic [invaders_pkg::COLOR_W-1:0] next_rgb;

	//////////////////////////////
	// mode cycle blank, start, game, blank
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode <= invaders_pkg::MODE_BLANK;
			restart <= 1'b0;
		end else begin
			// one cycle pulse behind every display press
			restart <= button_display;
			if (button_display) begin
				if (mode == invaders_pkg::MODE_GAME)
					mode <= invaders_pkg::MODE_BLANK;
				else
					mode <= mode + 2'd1;
			end
		end
	end

	assign game_run = (mode == invaders_pkg::MODE_GAME);

	assign visible = (x_coord < invaders_pkg::SCREEN_W) && (y_coord < invaders_pkg::SCREEN_H);

	//////////////////////////////
	// fixed priority, borders over every layer
	always_comb begin
		next_rgb = invaders_pkg::COLOR_SPACE;
		if (visible) begin
			case (mode)
				invaders_pkg::MODE_START: next_rgb = invaders_pkg::COLOR_WHITE;
				invaders_pkg::MODE_GAME: begin
					if (y_coord == '0 || y_coord == invaders_pkg::SCOREBOARD_BOTTOM)
						next_rgb = invaders_pkg::COLOR_RED;
					else if (y_coord == invaders_pkg::BARRIER_TOP ||
							y_coord == invaders_pkg::BARRIER_BOTTOM)
						next_rgb = invaders_pkg::COLOR_BLUE;
					else if (y_coord == invaders_pkg::EXTRA_LIVES_TOP)
						next_rgb = invaders_pkg::COLOR_GREEN;
					else if (ship_px)
						next_rgb = invaders_pkg::COLOR_SHIP;
					else if (laser_px)
						next_rgb = invaders_pkg::COLOR_LASER;
					else if (alien_px)
						next_rgb = invaders_pkg::COLOR_ALIEN;
				end
				// blank and the unused code stay black
				default: next_rgb = invaders_pkg::COLOR_SPACE;
			endcase
		end
	end

	// one cycle behind the scan coordinates
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rgb <= '0;
		else
			rgb <= next_rgb;
	end

endmodule

//--- src/invaders_top.sv
`timescale 1ns/1ns

module invaders_top (
	input  logic clk,
	input  logic rst,
	input  logic frame_tick,
	input  logic button_left,
	input  logic button_right,
	input  logic button_shoot,
	input  logic button_display,
	input  logic [invaders_pkg::COORD_W-1:0] x_coord,
	input  logic [invaders_pkg::COORD_W-1:0] y_coord,
	output logic [invaders_pkg::COLOR_W-1:0] rgb
);

	// mode control from the compositor to both layers
	logic game_run;
	logic restart;
	// layer flags for the current pixel
	logic ship_px;
	logic laser_px;
	logic alien_px;

	// laser state one way, hit report the other
	shot_if shot ();

	player_ship i_ship (
		.clk          (clk),
		.rst          (rst),
		.frame_tick   (frame_tick),
		.game_run     (game_run),
		.restart      (restart),
		.button_left  (button_left),
		.button_right (button_right),
		.button_shoot (button_shoot),
		.x_coord      (x_coord),
		.y_coord      (y_coord),
		.shot         (shot.shooter),
		.ship_px      (ship_px),
		.laser_px     (laser_px)
	);

	alien_formation i_formation (
		.clk        (clk),
		.rst        (rst),
		.frame_tick (frame_tick),
		.game_run   (game_run),
		.restart    (restart),
		.x_coord    (x_coord),
		.y_coord    (y_coord),
		.shot       (shot.target),
		.alien_px   (alien_px)
	);

	screen_compositor i_compositor (
		.clk            (clk),
		.rst            (rst),
		.button_display (button_display),
		.x_coord        (x_coord),
		.y_coord        (y_coord),
		.ship_px        (ship_px),
		.laser_px       (laser_px),
		.alien_px       (alien_px),
		.game_run       (game_run),
		.restart        (restart),
		.rgb            (rgb)
	);

endmodule

//--- tb/invaders_model.svh
`ifndef INVADERS_MODEL_SVH
`define INVADERS_MODEL_SVH

typedef logic [invaders_pkg::COORD_W-1:0] coord_t;

localparam int NUM_ALIENS = invaders_pkg::ALIEN_ROWS * invaders_pkg::ALIEN_COLS;

//////////////////////////////
// reference game state
logic [1:0] model_mode;
logic model_restart;
coord_t ship_pos;
logic shot_active;
coord_t shot_x;
coord_t shot_y;
coord_t march_off;
coord_t drop_off;
logic march_right;
// row major, row 0 on top
logic [NUM_ALIENS-1:0] alive_mask;

// ship, laser and formation back home
task automatic place_home();
	ship_pos = invaders_pkg::SHIP_X0;
	shot_active = 1'b0;
	march_off = '0;
	drop_off = '0;
	march_right = 1'b1;
	alive_mask = '1;
endtask

task automatic reset_model();
	model_mode = invaders_pkg::MODE_BLANK;
	model_restart = 1'b0;
	shot_x = '0;
	shot_y = '0;
	place_home();
endtask

function automatic coord_t alien_x(input int idx);
	return invaders_pkg::ALIEN_X0 + march_off +
		coord_t'(idx % invaders_pkg::ALIEN_COLS) * invaders_pkg::ALIEN_PITCH_X;
endfunction

function automatic coord_t alien_y(input int idx);
	return invaders_pkg::ALIEN_Y0 + drop_off +
		coord_t'(idx / invaders_pkg::ALIEN_COLS) * invaders_pkg::ALIEN_PITCH_Y;
endfunction

// point inside a box given by corner and size
function automatic logic in_box(input coord_t x, input coord_t y, input coord_t bx,
		input coord_t by, input coord_t bw, input coord_t bh);
	return (x >= bx) && (x < bx + bw) && (y >= by) && (y < by + bh);
endfunction

// lowest living alien under the laser, -1 if none
function automatic int hit_index();
	for (int i = 0; i < NUM_ALIENS; i++) begin
		if (shot_active && alive_mask[i] &&
				shot_x < alien_x(i) + invaders_pkg::ALIEN_W &&
				shot_x + invaders_pkg::LASER_W > alien_x(i) &&
				shot_y < alien_y(i) + invaders_pkg::ALIEN_H &&
				shot_y + invaders_pkg::LASER_H > alien_y(i))
			return i;
	end
	return -1;
endfunction

//////////////////////////////
// color of one scan position for the current state
function automatic logic [7:0] expected_pixel(input coord_t x, input coord_t y);
	logic on_alien;
	on_alien = 1'b0;
	for (int i = 0; i < NUM_ALIENS; i++) begin
		if (alive_mask[i] && in_box(x, y, alien_x(i), alien_y(i),
				invaders_pkg::ALIEN_W, invaders_pkg::ALIEN_H))
			on_alien = 1'b1;
	end
	if (x >= invaders_pkg::SCREEN_W || y >= invaders_pkg::SCREEN_H)
		return invaders_pkg::COLOR_SPACE;
	if (model_mode == invaders_pkg::MODE_START)
		return invaders_pkg::COLOR_WHITE;
	if (model_mode != invaders_pkg::MODE_GAME)
		return invaders_pkg::COLOR_SPACE;
	// divider rows win over every layer
	if (y == '0 || y == invaders_pkg::SCOREBOARD_BOTTOM)
		return invaders_pkg::COLOR_RED;
	if (y == invaders_pkg::BARRIER_TOP || y == invaders_pkg::BARRIER_BOTTOM)
		return invaders_pkg::COLOR_BLUE;
	if (y == invaders_pkg::EXTRA_LIVES_TOP)
		return invaders_pkg::COLOR_GREEN;
	if (in_box(x, y, ship_pos, invaders_pkg::SHIP_Y, invaders_pkg::SHIP_W, invaders_pkg::SHIP_H))
		return invaders_pkg::COLOR_SHIP;
	if (shot_active &&
			in_box(x, y, shot_x, shot_y, invaders_pkg::LASER_W, invaders_pkg::LASER_H))
		return invaders_pkg::COLOR_LASER;
	if (on_alien)
		return invaders_pkg::COLOR_ALIEN;
	return invaders_pkg::COLOR_SPACE;
endfunction

//////////////////////////////
// one clock edge with the inputs sampled there
task automatic advance_model(input logic tick, input logic left, input logic right,
		input logic shoot, input logic display);
	int hit;
	hit = hit_index();
	if (model_restart) begin
		place_home();
	end else if (tick && model_mode == invaders_pkg::MODE_GAME) begin
		// laser launch sees the ship before it moves
		if (shot_active) begin
			if (hit >= 0 || shot_y < invaders_pkg::SCOREBOARD_BOTTOM + invaders_pkg::LASER_STEP)
				shot_active = 1'b0;
			else
				shot_y = shot_y - invaders_pkg::LASER_STEP;
		end else if (shoot) begin
			shot_active = 1'b1;
			shot_x = ship_pos + (invaders_pkg::SHIP_W - invaders_pkg::LASER_W) / 11'd2;
			shot_y = invaders_pkg::SHIP_Y - invaders_pkg::LASER_H;
		end
		if (left)
			ship_pos = (ship_pos >= invaders_pkg::SHIP_STEP) ?
				ship_pos - invaders_pkg::SHIP_STEP : '0;
		else if (right)
			ship_pos = (ship_pos + invaders_pkg::SHIP_STEP >
				invaders_pkg::SCREEN_W - invaders_pkg::SHIP_W) ?
				invaders_pkg::SCREEN_W - invaders_pkg::SHIP_W : ship_pos + invaders_pkg::SHIP_STEP;
		if (hit >= 0)
			alive_mask[hit] = 1'b0;
		// drop and turn at either end of the march
		if ((march_right && march_off == invaders_pkg::MARCH_RANGE) ||
				(!march_right && march_off == '0)) begin
			drop_off = drop_off + invaders_pkg::DROP_STEP;
			march_right = !march_right;
		end else if (march_right) begin
			march_off = march_off + invaders_pkg::MARCH_STEP;
		end else begin
			march_off = march_off - invaders_pkg::MARCH_STEP;
		end
	end
	model_restart = display;
	if (display)
		model_mode = (model_mode == invaders_pkg::MODE_GAME) ?
			invaders_pkg::MODE_BLANK : model_mode + 2'd1;
endtask

`endif

//--- tb/tb_invaders.sv
`timescale 1ns/1ns

module tb_invaders;

	localparam int RESET_CYCLES = 4;
	localparam int FRAME_CYCLES = 8;
	localparam int BLANK_CYCLES = 200;
	localparam int START_CYCLES = 200;
	localparam int GAME_CYCLES = 2400;
	localparam int REGAME_CYCLES = 800;
	// blank and start phases each run twice
	localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * BLANK_CYCLES + 2 * START_CYCLES +
		GAME_CYCLES + REGAME_CYCLES;
	localparam int CYCLE_LIMIT = TOTAL_CYCLES + TOTAL_CYCLES / 10;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic frame_tick = 1'b0;
	logic button_left = 1'b0;
	logic button_right = 1'b0;
	logic button_shoot = 1'b0;
	logic button_display = 1'b0;
	logic [invaders_pkg::COORD_W-1:0] x_coord = '0;
	logic [invaders_pkg::COORD_W-1:0] y_coord = '0;
	logic [invaders_pkg::COLOR_W-1:0] rgb;
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	int frame_phase = 0;

	`include "invaders_model.svh"

	localparam coord_t BORDER_ROWS [5] = '{11'd0, invaders_pkg::SCOREBOARD_BOTTOM,
		invaders_pkg::BARRIER_TOP, invaders_pkg::BARRIER_BOTTOM, invaders_pkg::EXTRA_LIVES_TOP};

	invaders_top i_dut (
		.clk            (clk),
		.rst            (rst),
		.frame_tick     (frame_tick),
		.button_left    (button_left),
		.button_right   (button_right),
		.button_shoot   (button_shoot),
		.button_display (button_display),
		.x_coord        (x_coord),
		.y_coord        (y_coord),
		.rgb            (rgb)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// hard stop if the phases overrun
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	//////////////////////////////
	// next scan position aimed at the interesting places
	task automatic drive_scan();
		int kind;
		int idx;
		coord_t sx;
		coord_t sy;
		kind = $urandom % 8;
		idx = $urandom % NUM_ALIENS;
		sx = coord_t'($urandom % 640);
		sy = coord_t'($urandom % 480);
		case (kind)
			0: sy = BORDER_ROWS[idx % 5];
			1: begin
				sx = ship_pos + coord_t'($urandom % 36) - 11'd3;
				sy = invaders_pkg::SHIP_Y + coord_t'($urandom % 16) - 11'd2;
			end
			2: begin
				sx = shot_x + coord_t'($urandom % 4) - 11'd1;
				sy = shot_y + coord_t'($urandom % 12) - 11'd2;
			end
			3, 4: begin
				sx = alien_x(idx) + coord_t'($urandom % 28) - 11'd2;
				sy = alien_y(idx) + coord_t'($urandom % 20) - 11'd2;
			end
			// anywhere including off-screen
			5: begin
				sx = coord_t'($urandom);
				sy = coord_t'($urandom);
			end
			default: ;
		endcase
		x_coord <= sx;
		y_coord <= sy;
	endtask

	// one clock with the pixel from this edge checked once it settles
	task automatic run_cycle(input string name, input logic display, input logic lean_right);
		logic [7:0] expected;
		@(posedge clk);
		expected = expected_pixel(x_coord, y_coord);
		advance_model(frame_tick, button_left, button_right, button_shoot, button_display);
		frame_phase = (frame_phase + 1) % FRAME_CYCLES;
		frame_tick <= (frame_phase == FRAME_CYCLES - 1);
		// button levels held for a whole frame
		if (frame_phase == 0) begin
			// ship drifts toward one edge so both clamps get reached
			if (lean_right) begin
				button_left <= ($urandom % 8) == 0;
				button_right <= ($urandom % 8) != 0;
			end else begin
				button_left <= ($urandom % 8) != 0;
				button_right <= 1'($urandom);
			end
			button_shoot <= ($urandom % 4) != 0;
		end
		button_display <= display;
		drive_scan();
		@(negedge clk);
		check_value(name, expected, rgb);
	endtask

	task automatic run_phase(input string name, input int cycles, input logic strobe,
			input logic lean_right);
		for (int i = 0; i < cycles; i++)
			run_cycle(name, strobe && i == 0, lean_right);
	endtask

	//////////////////////////////
	initial begin
		void'($urandom(53));
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		run_phase("blank", BLANK_CYCLES, 1'b0, 1'b0);
		run_phase("start", START_CYCLES, 1'b1, 1'b0);
		run_phase("game", GAME_CYCLES, 1'b1, 1'b1);
		run_phase("blank_again", BLANK_CYCLES, 1'b1, 1'b0);
		run_phase("start_again", START_CYCLES, 1'b1, 1'b0);
		// restart pulse brings everything home
		run_phase("regame", REGAME_CYCLES, 1'b1, 1'b0);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- list.f
+incdir+tb
src/invaders_pkg.sv
src/shot_if.sv
src/player_ship.sv
src/alien_formation.sv
src/screen_compositor.sv
src/invaders_top.sv
tb/tb_invaders.sv

//--- run.sh
#!/bin/sh
# build design and testbench with Verilator, run, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -f list.f --top-module tb_invaders -o sim_invaders \
	&& ./obj_dir/sim_invaders | tee /dev/stderr | grep -q "RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }
